/* src/board_pkg.sv */
`default_nettype none

package board_pkg;

    //######################################
    // Data widths
    //######################################

    typedef logic signed [23:0] sample_t;    // Left microphone sample
    typedef logic        [31:0] display_t;   // Eight hex nibbles
    typedef logic        [ 9:0] coord_t;     // Pixel or line number
    typedef logic        [ 3:0] color_t;     // One color channel
    typedef logic        [ 3:0] led_t;
    typedef logic        [ 2:0] key_t;       // Active high
    typedef logic        [ 7:0] segments_t;  // abcdefgh, active high
    typedef logic        [ 7:0] digit_sel_t; // One-hot, active high

    //######################################
    // VGA 640x480 at 25 MHz
    //######################################

    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;

    //######################################
    // Audio and slow timing
    //######################################

    localparam int sck_half            = 4;          // sck = clk / 8
    localparam int i2s_slots           = 32;
    localparam int tick_period_default = 25_000_000; // 1 Hz
    localparam int scan_period         = 25_000;     // 1 ms per digit

    // Index 0 is the lowest level, 2^19 up to 2^22
    localparam logic [3:0][23:0] level_thresholds = {
        24'h40_0000,
        24'h20_0000,
        24'h10_0000,
        24'h08_0000
    };

endpackage

`default_nettype wire

/* src/strobe_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module strobe_gen #(
    parameter int period = 1000
) (
    input  logic clk,
    input  logic reset,
    output logic strobe
);

    localparam int count_w = $clog2(period + 1);

    logic [count_w-1:0] count;

    // Down-counter, one pulse per wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            count  <= count_w'(period - 1);
            strobe <= 1'b0;
        end else if (count == '0) begin
            count  <= count_w'(period - 1); // Reload
            strobe <= 1'b1;
        end else begin
            count  <= count - 1'b1;
            strobe <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/i2s_mic_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module i2s_mic_receiver (
    input  logic               clk,
    input  logic               reset,
    input  logic               sd,
    output logic               sck,
    output logic               ws,
    output logic               lr,
    output board_pkg::sample_t sample,
    output logic               sample_valid
);

    import board_pkg::*;

    localparam int div_w  = $clog2(sck_half);
    localparam int slot_w = $clog2(2 * i2s_slots);

    logic [div_w-1:0]  div;
    logic [slot_w-1:0] slot;
    logic              div_wrap;
    logic              sck_rise;
    logic              sck_fall;
    logic [23:0]       shift;
    logic              capture_done;

    assign div_wrap = (div == div_w'(sck_half - 1));
    assign sck_rise = div_wrap && !sck;
    assign sck_fall = div_wrap && sck;

    assign ws = slot[slot_w-1];   // Low for the left half
    assign lr = 1'b0;             // Mic answers in the left slot

    //######################################
    // Bit clock and word select
    //######################################

    always_ff @(posedge clk) begin
        if (reset) begin
            div  <= '0;
            sck  <= 1'b0;
            slot <= '0;
        end else begin
            div <= div_wrap ? '0 : div + 1'b1;
            if (div_wrap)
                sck <= !sck;
            if (sck_fall)
                slot <= slot + 1'b1; // Wraps after both halves
        end
    end

    //######################################
    // Serial capture
    //######################################

    // MSB sits in slot 1, so after slot 24 the register holds the word
    always_ff @(posedge clk) begin
        if (sck_rise && !ws)
            shift <= {shift[22:0], sd};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            capture_done <= 1'b0;
            sample_valid <= 1'b0;
            sample       <= '0;
        end else begin
            capture_done <= sck_rise && !ws && (slot == slot_w'(24));
            sample_valid <= capture_done;
            if (capture_done)
                sample <= shift;
        end
    end

endmodule

`default_nettype wire

/* src/vga_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_timing (
    input  logic              clk,
    input  logic              reset,
    output logic              hsync,
    output logic              vsync,
    output board_pkg::coord_t x,
    output board_pkg::coord_t y,
    output logic              visible
);

    import board_pkg::*;

    localparam int h_total      = h_visible + h_front + h_sync + h_back;
    localparam int v_total      = v_visible + v_front + v_sync + v_back;
    localparam int h_sync_start = h_visible + h_front;
    localparam int v_sync_start = v_visible + v_front;

    coord_t h_count;
    coord_t v_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            visible <= 1'b0;
        end else begin
            if (h_count == coord_t'(h_total - 1)) begin
                h_count <= '0;
                if (v_count == coord_t'(v_total - 1))
                    v_count <= '0;      // End of frame
                else
                    v_count <= v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end

            // Active low sync pulses
            hsync <= !((h_count >= coord_t'(h_sync_start))
                    && (h_count <  coord_t'(h_sync_start + h_sync)));
            vsync <= !((v_count >= coord_t'(v_sync_start))
                    && (v_count <  coord_t'(v_sync_start + v_sync)));
            visible <= (h_count < coord_t'(h_visible))
                    && (v_count < coord_t'(v_visible));
        end
    end

    // Coordinates line up with visible
    always_ff @(posedge clk) begin
        x <= h_count;
        y <= v_count;
    end

endmodule

`default_nettype wire

/* src/seven_seg_scanner.sv */
`timescale 1ns/10ps
`default_nettype none

module seven_seg_scanner (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  scan,
    input  board_pkg::display_t   display_value,
    input  logic [7:0]            blank_mask,
    output board_pkg::segments_t  abcdefgh,
    output board_pkg::digit_sel_t digit
);

    import board_pkg::*;

    logic [3:0] nibble;
    logic       blank;

    function automatic segments_t hex_font(input logic [3:0] value);
        segments_t pattern;
        case (value)            //   abcdefgh
            4'h0: pattern = 8'b1111_1100;
            4'h1: pattern = 8'b0110_0000;
            4'h2: pattern = 8'b1101_1010;
            4'h3: pattern = 8'b1111_0010;
            4'h4: pattern = 8'b0110_0110;
            4'h5: pattern = 8'b1011_0110;
            4'h6: pattern = 8'b1011_1110;
            4'h7: pattern = 8'b1110_0000;
            4'h8: pattern = 8'b1111_1110;
            4'h9: pattern = 8'b1111_0110;
            4'ha: pattern = 8'b1110_1110;
            4'hb: pattern = 8'b0011_1110; // Lowercase b
            4'hc: pattern = 8'b1001_1100;
            4'hd: pattern = 8'b0111_1010; // Lowercase d
            4'he: pattern = 8'b1001_1110;
            default: pattern = 8'b1000_1110;
        endcase
        return pattern;
    endfunction

    // One-hot select, digit 0 is the rightmost
    always_ff @(posedge clk) begin
        if (reset)
            digit <= digit_sel_t'(1);
        else if (scan)
            digit <= {digit[6:0], digit[7]};
    end

    always_comb begin
        nibble = '0;
        blank  = 1'b1;
        for (int i = 0; i < 8; i++) begin
            if (digit[i]) begin
                nibble = display_value[4 * i +: 4];
                blank  = blank_mask[i];
            end
        end
    end

    assign abcdefgh = blank ? '0 : hex_font(nibble);

endmodule

`default_nettype wire

/* src/lab_control.sv */
`timescale 1ns/10ps
`default_nettype none

module lab_control (
    input  logic                clk,
    input  logic                reset,
    input  board_pkg::key_t     key,
    input  logic                tick,
    input  board_pkg::sample_t  sample,
    input  logic                sample_valid,
    input  board_pkg::coord_t   x,
    input  board_pkg::coord_t   y,
    input  logic                visible,
    output board_pkg::led_t     led,
    output board_pkg::display_t display_value,
    output logic [7:0]          blank_mask,
    output board_pkg::color_t   red,
    output board_pkg::color_t   green,
    output board_pkg::color_t   blue
);

    import board_pkg::*;

    logic        counter_mode;
    logic        freeze;
    logic        clear;
    display_t    counter;
    logic [23:0] magnitude;
    logic [2:0]  level_next;
    logic [2:0]  level;
    led_t        level_bar;
    coord_t      bar_end;
    logic        active;
    logic        in_bar;

    assign counter_mode = key[0];
    assign freeze       = key[1];
    assign clear        = key[2];

    //######################################
    // Counter and sound level
    //######################################

    always_ff @(posedge clk) begin
        if (reset || clear)
            counter <= '0;
        else if (tick)
            counter <= counter + 1'b1;
    end

    assign magnitude = sample[23] ? 24'(-sample) : 24'(sample);

    // Thresholds ascend, last hit wins
    always_comb begin
        level_next = '0;
        for (int i = 0; i < 4; i++) begin
            if (magnitude >= level_thresholds[i])
                level_next = 3'(i + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            level <= '0;
        else if (sample_valid)
            level <= level_next;
    end

    always_comb begin
        for (int i = 0; i < 4; i++)
            level_bar[i] = (level > 3'(i));
    end

    assign led = counter_mode ? counter[3:0] : level_bar;

    //######################################
    // Digits
    //######################################

    always_ff @(posedge clk) begin
        if (reset) begin
            display_value <= '0;
            blank_mask    <= 8'hc0;
        end else if (!freeze) begin
            if (counter_mode) begin
                display_value <= counter;
                blank_mask    <= 8'h00;
            end else begin
                display_value <= {8'h00, sample};
                blank_mask    <= 8'hc0;    // Only six nibbles used
            end
        end
    end

    //######################################
    // Level bar on screen
    //######################################

    assign bar_end = coord_t'(level) * coord_t'(160);
    assign active  = visible && (y < coord_t'(v_visible));
    assign in_bar  = (x < bar_end);

    assign red   = (active && in_bar)  ? 4'hf : 4'h0;
    assign green = (active && !in_bar) ? 4'hf : 4'h0;
    assign blue  = '0;

endmodule

`default_nettype wire

/* src/board_top.sv */
`timescale 1ns/10ps
`default_nettype none

module board_top #(
    parameter int tick_period = board_pkg::tick_period_default
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] key_n,
    output logic [3:0] led,
    output logic [7:0] seg_data,
    output logic [7:0] seg_sel,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic [4:0] vga_r,
    output logic [5:0] vga_g,
    output logic [4:0] vga_b,
    input  logic       mic_sd,
    output logic       mic_sck,
    output logic       mic_ws,
    output logic       mic_lr
);

    import board_pkg::*;

    key_t       key;
    logic       tick;
    logic       scan;
    sample_t    sample;
    logic       sample_valid;
    coord_t     x;
    coord_t     y;
    logic       visible;
    display_t   display_value;
    logic [7:0] blank_mask;
    segments_t  abcdefgh;
    digit_sel_t digit;
    color_t     red;
    color_t     green;
    color_t     blue;

    assign key = ~key_n;   // Keys pull low when pressed

    strobe_gen #(.period(tick_period)) i_tick_gen (
        .clk    ( clk   ),
        .reset  ( reset ),
        .strobe ( tick  )
    );

    strobe_gen #(.period(scan_period)) i_scan_gen (
        .clk    ( clk   ),
        .reset  ( reset ),
        .strobe ( scan  )
    );

    i2s_mic_receiver i_microphone (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sd           ( mic_sd       ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .lr           ( mic_lr       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    vga_timing i_vga_timing (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .hsync   ( vga_hs  ),
        .vsync   ( vga_vs  ),
        .x       ( x       ),
        .y       ( y       ),
        .visible ( visible )
    );

    seven_seg_scanner i_scanner (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .scan          ( scan          ),
        .display_value ( display_value ),
        .blank_mask    ( blank_mask    ),
        .abcdefgh      ( abcdefgh      ),
        .digit         ( digit         )
    );

    lab_control i_control (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .key           ( key           ),
        .tick          ( tick          ),
        .sample        ( sample        ),
        .sample_valid  ( sample_valid  ),
        .x             ( x             ),
        .y             ( y             ),
        .visible       ( visible       ),
        .led           ( led           ),
        .display_value ( display_value ),
        .blank_mask    ( blank_mask    ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          )
    );

    // Board segments and digit selects are active low
    assign seg_data = ~abcdefgh;
    assign seg_sel  = ~digit;

    assign vga_r = {red,   1'b0};
    assign vga_g = {green, 2'b0};  // Green pins are 6 bits wide
    assign vga_b = {blue,  1'b0};

endmodule

`default_nettype wire

/* bench/board_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module board_assertions (
    input logic       clk,
    input logic       reset,
    input logic [7:0] seg_sel,
    input logic       vga_hs,
    input logic       vga_vs,
    input logic [4:0] vga_r,
    input logic [5:0] vga_g,
    input logic [4:0] vga_b
);

    int   fail_count = 0;
    int   hs_low_len;
    int   hs_gap;          // Cycles since the last hsync fall
    int   vs_low_len;
    logic hs_q;
    logic hs_started;

    always @(posedge clk) begin
        if (reset) begin
            hs_low_len <= 0;
            hs_gap     <= 0;
            vs_low_len <= 0;
            hs_q       <= 1'b1;
            hs_started <= 1'b0;
        end else begin
            hs_low_len <= vga_hs ? 0 : hs_low_len + 1;
            vs_low_len <= vga_vs ? 0 : vs_low_len + 1;
            hs_q       <= vga_hs;
            if (hs_q && !vga_hs) begin
                hs_gap     <= 1;
                hs_started <= 1'b1;
            end else begin
                hs_gap <= hs_gap + 1;
            end
        end
    end

    //######################################
    // Digit scan
    //######################################

    scan_one_hot: assert property (@(posedge clk) disable iff (reset)
        $onehot(~seg_sel))
        else begin
            fail_count = fail_count + 1;
            $error("seg_sel does not select exactly one digit: %h", seg_sel);
        end

    scan_step: assert property (@(posedge clk) disable iff (reset)
        !$stable(seg_sel) |-> seg_sel == {$past(seg_sel[6:0]), $past(seg_sel[7])})
        else begin
            fail_count = fail_count + 1;
            $error("seg_sel did not move to the next digit: %h", seg_sel);
        end

    //######################################
    // VGA sync
    //######################################

    hs_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_hs) |-> hs_low_len == 96)
        else begin
            fail_count = fail_count + 1;
            $error("hsync pulse lasted %0d cycles", hs_low_len);
        end

    hs_period: assert property (@(posedge clk) disable iff (reset)
        ($fell(vga_hs) && hs_started) |-> hs_gap == 800)
        else begin
            fail_count = fail_count + 1;
            $error("hsync falling edges %0d cycles apart", hs_gap);
        end

    vs_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_vs) |-> vs_low_len == 1600)
        else begin
            fail_count = fail_count + 1;
            $error("vsync pulse lasted %0d cycles", vs_low_len);
        end

    dark_in_sync: assert property (@(posedge clk) disable iff (reset)
        (!vga_hs || !vga_vs) |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
        else begin
            fail_count = fail_count + 1;
            $error("color output not zero during sync");
        end

endmodule

bind board_top board_assertions i_assertions (
    .clk     ( clk      ),
    .reset   ( reset    ),
    .seg_sel ( seg_sel  ),
    .vga_hs  ( vga_hs   ),
    .vga_vs  ( vga_vs   ),
    .vga_r   ( vga_r    ),
    .vga_g   ( vga_g    ),
    .vga_b   ( vga_b    )
);

`default_nettype wire

/* bench/tb_board_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    localparam int clk_period   = 40;
    localparam int tick_cycles  = 2000;
    localparam int frame_cycles = 800 * 525;
    localparam int watchdog_ns  = 3 * frame_cycles * clk_period + 200_000;

    // abcdefgh patterns for hex digits 0 to F
    localparam logic [7:0] font [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    logic        clk = 1'b0;
    logic        reset;
    logic [2:0]  key_n;
    logic [3:0]  led;
    logic [7:0]  seg_data;
    logic [7:0]  seg_sel;
    logic        vga_hs;
    logic        vga_vs;
    logic [4:0]  vga_r;
    logic [5:0]  vga_g;
    logic [4:0]  vga_b;
    logic        mic_sd = 1'b0;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;

    logic [23:0] mic_word   = '0;   // Word the microphone sends next
    logic [23:0] tx_shift   = '0;
    logic        last_ws    = 1'b1;
    int          period_idx = 63;   // sck period within the 64-period frame
    int          words_sent = 0;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [23:0] word_a;
    logic [23:0] word_b;
    int          cycles;
    logic [3:0]  prev_led;
    logic [3:0]  next_led;

    always #(clk_period / 2) clk = ~clk;

    board_top #(.tick_period(tick_cycles)) uut (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .key_n    ( key_n    ),
        .led      ( led      ),
        .seg_data ( seg_data ),
        .seg_sel  ( seg_sel  ),
        .vga_hs   ( vga_hs   ),
        .vga_vs   ( vga_vs   ),
        .vga_r    ( vga_r    ),
        .vga_g    ( vga_g    ),
        .vga_b    ( vga_b    ),
        .mic_sd   ( mic_sd   ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   )
    );

    //######################################
    // Microphone model
    //######################################

    // Rising sck counts periods and falling sck puts out the next bit
    always @(mic_sck) begin
        if (mic_sck === 1'b1) begin
            if (!mic_ws && last_ws) begin
                period_idx <= 0;            // Left half begins
                tx_shift   <= mic_word;
            end else begin
                period_idx <= period_idx + 1;
            end
            if (mic_ws && !last_ws)
                words_sent <= words_sent + 1;
            last_ws <= mic_ws;
        end else if (period_idx < 24) begin
            mic_sd   <= tx_shift[23];       // MSB goes out for period 1
            tx_shift <= {tx_shift[22:0], 1'b0};
        end else begin
            mic_sd <= 1'b0;
        end
    end

    //######################################
    // Helpers
    //######################################

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    // Number of thresholds 2^19 to 2^22 that the magnitude reaches
    function automatic logic [3:0] level_bar(input logic [23:0] word);
        int value;
        int level;
        value = {{8{word[23]}}, word};
        if (value < 0)
            value = -value;
        level = 0;
        for (int k = 19; k <= 22; k++) begin
            if (value >= (1 << k))
                level++;
        end
        return 4'((1 << level) - 1);
    endfunction

    task automatic send_sample(input logic [23:0] word);
        int target;
        @(negedge clk);
        mic_word = word;
        target   = words_sent + 2;      // One full word after the change
        wait (words_sent >= target);
        repeat (2) @(negedge clk);
    endtask

    task automatic check_reset_state();
        expect_value("vga_hs", 32'(vga_hs), 32'd1);
        expect_value("vga_vs", 32'(vga_vs), 32'd1);
        expect_value("led", 32'(led), 32'd0);
        expect_value("seg_sel", 32'(seg_sel), 32'hfe);
        expect_value("vga_r", 32'(vga_r), 32'd0);
        expect_value("vga_g", 32'(vga_g), 32'd0);
        expect_value("vga_b", 32'(vga_b), 32'd0);
    endtask

    // Watches one full scan and reports the first mismatch per digit
    task automatic check_digits(input logic [31:0] value);
        logic [7:0] seen;
        logic [7:0] bad;
        logic [7:0] expected;
        seen = '0;
        bad  = '0;
        repeat (8 * scan_period + 8) begin
            @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                if (!seg_sel[i]) begin
                    seen[i]  = 1'b1;
                    expected = (i < 6) ? ~font[value[4 * i +: 4]] : 8'hff;
                    if (seg_data !== expected && !bad[i]) begin
                        bad[i] = 1'b1;
                        expect_value($sformatf("seg_data of digit %0d", i),
                                     32'(seg_data), 32'(expected));
                    end
                end
            end
        end
        if (seen != 8'hff) begin
            $display("the digit scan did not reach every digit in one scan period");
            errors++;
        end
    endtask

    task automatic cycles_to_led_change(output int count);
        logic [3:0] start;
        start = led;
        count = 0;
        while (led == start && count < 2 * tick_cycles) begin
            @(negedge clk);
            count++;
        end
    endtask

    //######################################
    // Tests
    //######################################

    initial begin
        void'($urandom(69556));
        reset        = 1'b1;
        key_n        = 3'b111;          // No key pressed
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_reset_state();
        finish_test("reset state");

        word_a = 24'($urandom);
        send_sample(word_a);
        @(negedge vga_vs);              // Let the next frame pass
        check_digits({8'h00, word_a});
        expect_value("led", 32'(led), 32'(level_bar(word_a)));
        expect_value("mic_lr", 32'(mic_lr), 32'd0);
        finish_test("sample display");

        @(posedge clk);
        key_n <= 3'b101;                // Hold freeze
        word_b = word_a ^ (24'($urandom) | 24'h111111);  // Every nibble differs
        send_sample(word_b);
        check_digits({8'h00, word_a});
        @(posedge clk);
        key_n <= 3'b111;
        repeat (2) @(negedge clk);
        check_digits({8'h00, word_b});
        expect_value("led", 32'(led), 32'(level_bar(word_b)));
        finish_test("freeze");

        @(posedge clk);
        key_n <= 3'b110;                // Counter mode
        @(negedge clk);
        cycles_to_led_change(cycles);   // Line up with a tick
        repeat (5) begin
            prev_led = led;
            next_led = prev_led + 4'd1;
            cycles_to_led_change(cycles);
            if (cycles != tick_cycles) begin
                $display("led changed after %0d cycles instead of %0d", cycles, tick_cycles);
                errors++;
            end
            expect_value("led", 32'(led), 32'(next_led));
        end
        if (led == 4'd0)
            cycles_to_led_change(cycles);   // Clear has to start from a nonzero count
        @(posedge clk);
        key_n <= 3'b010;                // Clear while counting
        @(posedge clk);
        @(negedge clk);
        expect_value("led", 32'(led), 32'd0);
        @(posedge clk);
        key_n <= 3'b111;
        finish_test("counter mode");

        $display("%0d tests run, %0d failed, %0d assertion failures",
                 tests_run, tests_failed, uut.i_assertions.fail_count);
        if (tests_failed == 0 && uut.i_assertions.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Three frames plus some margin
    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/board_pkg.sv
src/strobe_gen.sv
src/i2s_mic_receiver.sv
src/vga_timing.sv
src/seven_seg_scanner.sv
src/lab_control.sv
src/board_top.sv
bench/board_assertions.sv
bench/tb_board_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --top-module tb_board_top \
        -f verilog.f --Mdir obj_dir -o tb_board_top; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_board_top +verilator+error+limit+100 > "$log" 2>&1; then
    cat "$log"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$log"

if grep -q "^All tests passed$" "$log"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
